//--- tests/fetch_vectors.txt
# op a b expect, all hex
# 1 accept, 2 flush cause epc, 3 csr sel val, 5 irq bits epc, 6 mispredict pc tgt, 7 taken pc tgt
# 8 arm miss, 9 deliver pred, a ibuf backpressure on/off, b count sequential deliveries
1 0 0 80000000
1 0 0 80000010
1 0 0 80000020
b 4 0 80000000
3 0 80001000 0
3 1 80002000 0
3 2 80003000 0
3 3 80003800 0
3 4 0 0
2 10 80000104 80000108
1 0 0 80000110
2 12 0 80003000
2 8 0 80001000
3 4 100 0
2 8 0 80002000
5 8 80000200 8000101c
1 0 0 80001020
6 80004000 80004040 80004040
1 0 0 80004050
2 11 80005000 80005000
8 0 0 0
b 6 0 80005000
7 80006004 80007000 0
2 11 80006000 80006000
1 0 0 80007000
1 0 0 80007010
9 0 0 80006000
9 0 1 80007000
9 0 0 80007010
a 1 0 0
2 11 80008000 80008000
b 10 0 80008000
a 0 0 0

//--- compile.f
+incdir+logic
logic/fetch_pkg.sv
logic/redirect_target.sv
logic/fetch_sequencer.sv
logic/branch_predictor.sv
logic/fetch_frontend.sv
tests/fetch_frontend_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := fetch_frontend_tb
FILELIST  := compile.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All checks passed
SRCS      := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM) tests/fetch_vectors.txt
	$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/fetch_frontend_tb.sv
// ==============================
// fetch frontend testbench
// cache and ibuf models, vector-driven checks
// ==============================

`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_frontend_tb;
  import fetch_pkg::*;

  localparam int timeout_cycles = 200;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic       i_clk;
  logic       i_reset_n;
  commit_t    i_commit;
  csr_info_t  i_csr;
  int_req_t   i_int;
  br_upd_t    i_br_upd;
  ic_req_t    o_ic_req;
  logic       i_ic_ready;
  ic_resp_t   i_ic_resp;
  logic       i_ibuf_ready;
  fetch_out_t o_fetch;

  vaddr_t     acc_q[$];     // accepted request addresses
  fetch_out_t fetch_q[$];   // delivered lines
  ic_resp_t   acc_k;        // this cycle's acceptance, seen at negedge
  ic_resp_t   resp_d1;
  logic       miss_arm;
  logic       bp_en;
  int         stall_cnt;
  int         errors;
  int         timeouts;
  logic [31:0] lfsr;

  fetch_frontend UUT (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_csr        (i_csr),
    .i_int        (i_int),
    .i_br_upd     (i_br_upd),
    .o_ic_req     (o_ic_req),
    .i_ic_ready   (i_ic_ready),
    .i_ic_resp    (i_ic_resp),
    .i_ibuf_ready (i_ibuf_ready),
    .o_fetch      (o_fetch)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // galois step, one bit out per call
  function automatic logic lfsr_take();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ lfsr_taps;
    return b;
  endfunction

  // ==============================
  // monitor and cache / ibuf models
  // ==============================
  always @(negedge i_clk) begin
    acc_k = '0;
    if (i_reset_n && o_ic_req.valid && i_ic_ready) begin
      acc_q.push_back(o_ic_req.vaddr);
      acc_k.valid = 1'b1;
      acc_k.vaddr = o_ic_req.vaddr;
      if (miss_arm) begin
        acc_k.miss = 1'b1;
        miss_arm   = 1'b0;
      end
    end
    if (o_fetch.valid) fetch_q.push_back(o_fetch);
  end

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      resp_d1   <= acc_k;
      i_ic_resp <= resp_d1;        // two cycles after acceptance
      if (resp_d1.valid && resp_d1.miss) stall_cnt = 1 + {lfsr_take(), lfsr_take(), lfsr_take()};
      if (stall_cnt > 0) begin
        i_ic_ready <= 1'b0;        // line fill in progress
        stall_cnt  = stall_cnt - 1;
      end else begin
        i_ic_ready <= 1'b1;
      end
      i_ibuf_ready <= bp_en ? lfsr_take() : 1'b1;
    end
  end

  // ==============================
  // compare tasks
  // ==============================
  task automatic check_vaddr(input string name, input vaddr_t got, input vaddr_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_fetch(input string name, input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_accept(input vaddr_t exp);
    int t;
    for (t = 0; t < timeout_cycles && acc_q.size() == 0; t++) @(posedge i_clk);
    if (acc_q.size() == 0) begin
      timeouts++;
      $display("timeout at %0t: no request accepted, expected %h", $time, exp);
    end else begin
      check_vaddr("o_ic_req.vaddr", acc_q.pop_front(), exp);
    end
  endtask

  task automatic expect_fetch(input vaddr_t exp, input logic pred);
    int t;
    fetch_out_t want;
    want = '{valid: 1'b1, predicted: pred, vaddr: exp};
    for (t = 0; t < timeout_cycles && fetch_q.size() == 0; t++) @(posedge i_clk);
    if (fetch_q.size() == 0) begin
      timeouts++;
      $display("timeout at %0t: no line delivered, expected %h", $time, exp);
    end else begin
      check_fetch("o_fetch", fetch_q.pop_front(), want);
    end
  endtask

  // one-cycle strobe, stale queues dropped as the redirect lands
  task automatic drive_commit(input logic flush, input except_t cause, input vaddr_t epc,
                              input int_req_t irq);
    @(posedge i_clk);
    acc_q.delete();
    fetch_q.delete();
    i_commit <= '{valid: 1'b1, flush: flush, cause: cause, epc: epc};
    i_int    <= irq;
    @(posedge i_clk);
    i_commit <= '0;
    i_int    <= '0;
  endtask

  task automatic drive_br(input logic mispred, input vaddr_t pc, input vaddr_t target);
    @(posedge i_clk);
    if (mispred) begin
      acc_q.delete();
      fetch_q.delete();
    end
    i_br_upd <= '{valid: 1'b1, mispredict: mispred, taken: ~mispred, pc: pc, target: target};
    @(posedge i_clk);
    i_br_upd <= '0;
  endtask

  task automatic set_csr(input logic [63:0] sel, input logic [63:0] val);
    case (sel)
      0:       i_csr.mtvec   <= vaddr_t'(val);
      1:       i_csr.stvec   <= vaddr_t'(val);
      2:       i_csr.mepc    <= vaddr_t'(val);
      3:       i_csr.sepc    <= vaddr_t'(val);
      default: i_csr.medeleg <= val[15:0];
    endcase
  endtask

  // ==============================
  // vector runner
  // ==============================
  initial begin
    int fd;
    int n;
    int i;
    string line;
    logic [63:0] op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] ex;

    i_reset_n    = 1'b0;
    i_commit     = '0;
    i_csr        = '0;
    i_int        = '0;
    i_br_upd     = '0;
    i_ic_ready   = 1'b1;
    i_ic_resp    = '0;
    i_ibuf_ready = 1'b1;
    resp_d1      = '0;
    acc_k        = '0;
    miss_arm     = 1'b0;
    bp_en        = 1'b0;
    stall_cnt    = 0;
    errors       = 0;
    timeouts     = 0;
    lfsr         = 32'd83939;

    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;

    fd = $fopen("tests/fetch_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h", op, a, b, ex);
          if (n == 4) begin
            case (op)
              1: expect_accept(vaddr_t'(ex));
              2: begin
                drive_commit(1'b1, except_t'(a[4:0]), vaddr_t'(b), '0);
                expect_accept(vaddr_t'(ex));
              end
              3: set_csr(a, b);
              5: begin
                drive_commit(1'b0, except_t'(5'd0), vaddr_t'(b), int_req_t'(a[5:0]));
                expect_accept(vaddr_t'(ex));
              end
              6: begin
                drive_br(1'b1, vaddr_t'(a), vaddr_t'(b));
                expect_accept(vaddr_t'(ex));
              end
              7: drive_br(1'b0, vaddr_t'(a), vaddr_t'(b));
              8: miss_arm = 1'b1;
              9: expect_fetch(vaddr_t'(ex), b[0]);
              10: bp_en <= a[0];
              11: begin
                for (i = 0; i < int'(a); i++) begin
                  expect_fetch(vaddr_t'(ex) + vaddr_t'(i * `FETCH_LINE_BYTES), 1'b0);
                end
              end
              default: begin
                errors++;
                $display("unknown operation %h in the vector file", op);
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- logic/fetch_frontend.sv
// ==============================
// fetch frontend top
// redirect select, fetch sequencer and BTB
// ==============================

`timescale 1ns/100ps

module fetch_frontend (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // commit and resolution side
  input  fetch_pkg::commit_t    i_commit,
  input  fetch_pkg::csr_info_t  i_csr,
  input  fetch_pkg::int_req_t   i_int,
  input  fetch_pkg::br_upd_t    i_br_upd,

  // instruction cache
  output fetch_pkg::ic_req_t    o_ic_req,
  input  logic                  i_ic_ready,
  input  fetch_pkg::ic_resp_t   i_ic_resp,

  // instruction buffer
  input  logic                  i_ibuf_ready,
  output fetch_pkg::fetch_out_t o_fetch
);
  import fetch_pkg::*;

  redirect_t w_redirect;
  pred_t     w_pred;     // s1 answer for last accepted request

  redirect_target u_redirect_target (
    .i_commit   (i_commit),
    .i_csr      (i_csr),
    .i_int      (i_int),
    .i_br_upd   (i_br_upd),
    .o_redirect (w_redirect)
  );

  fetch_sequencer u_fetch_sequencer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_redirect   (w_redirect),
    .i_ic_ready   (i_ic_ready),
    .i_ic_resp    (i_ic_resp),
    .i_pred       (w_pred),
    .i_ibuf_ready (i_ibuf_ready),
    .o_ic_req     (o_ic_req),
    .o_fetch      (o_fetch)
  );

  branch_predictor u_branch_predictor (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ic_req   (o_ic_req),
    .i_ic_ready (i_ic_ready),
    .i_br_upd   (i_br_upd),
    .o_pred     (w_pred)
  );

endmodule

//--- logic/branch_predictor.sv
// ==============================
// branch target buffer
// direct-mapped by line, two-bit counters, answer at s1
// ==============================

`timescale 1ns/100ps
`include "fetch_params.svh"

module branch_predictor (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  fetch_pkg::ic_req_t i_ic_req,
  input  logic               i_ic_ready,
  input  fetch_pkg::br_upd_t i_br_upd,
  output fetch_pkg::pred_t   o_pred
);
  import fetch_pkg::*;

  localparam int ofs_w = `FETCH_LINE_OFS_W;
  localparam int idx_w = `FETCH_BTB_IDX_W;
  localparam int tag_w = `FETCH_VADDR_W - ofs_w - idx_w;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    vaddr_t           target;
    logic [1:0]       ctr;      // msb set means taken
  } btb_entry_t;

  logic [`FETCH_BTB_ENTRIES-1:0] r_valid;
  btb_entry_t                    r_entry [`FETCH_BTB_ENTRIES];

  logic [idx_w-1:0] w_upd_idx;
  logic [tag_w-1:0] w_upd_tag;
  btb_entry_t       w_upd_old;
  logic             w_upd_match;
  logic             w_wr_en;
  btb_entry_t       w_wr_entry;

  logic [idx_w-1:0] w_lk_idx;
  logic [tag_w-1:0] w_lk_tag;
  logic             w_lookup;
  logic             w_fwd;
  btb_entry_t       w_rd_entry;
  logic             w_rd_hit;

  logic             r_s1_hit;
  vaddr_t           r_s1_target;

  // ==============================
  // update from branch resolution
  // ==============================
  assign w_upd_idx   = i_br_upd.pc[ofs_w +: idx_w];
  assign w_upd_tag   = i_br_upd.pc[`FETCH_VADDR_W-1 -: tag_w];
  assign w_upd_old   = r_entry[w_upd_idx];
  assign w_upd_match = r_valid[w_upd_idx] & (w_upd_old.tag == w_upd_tag);
  assign w_wr_en     = i_br_upd.valid & (i_br_upd.taken | w_upd_match);

  always_comb begin
    w_wr_entry = w_upd_old;
    if (i_br_upd.taken) begin
      w_wr_entry.tag    = w_upd_tag;
      w_wr_entry.target = i_br_upd.target;
      if (!w_upd_match)                w_wr_entry.ctr = 2'b10;  // new entry, weakly taken
      else if (w_upd_old.ctr != 2'b11) w_wr_entry.ctr = w_upd_old.ctr + 2'd1;
    end else if (w_upd_old.ctr != 2'b00) begin
      w_wr_entry.ctr = w_upd_old.ctr - 2'd1;
    end
  end

  // ==============================
  // lookup at s0, with same-cycle update forwarded
  // ==============================
  assign w_lookup   = i_ic_req.valid & i_ic_ready;
  assign w_lk_idx   = i_ic_req.vaddr[ofs_w +: idx_w];
  assign w_lk_tag   = i_ic_req.vaddr[`FETCH_VADDR_W-1 -: tag_w];
  assign w_fwd      = w_wr_en & (w_upd_idx == w_lk_idx);
  assign w_rd_entry = w_fwd ? w_wr_entry : r_entry[w_lk_idx];
  assign w_rd_hit   = (w_fwd | r_valid[w_lk_idx]) & (w_rd_entry.tag == w_lk_tag) &
                      w_rd_entry.ctr[1];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_s1_hit <= 1'b0;
    end else begin
      if (w_wr_en) r_valid[w_upd_idx] <= 1'b1;
      r_s1_hit <= w_lookup & w_rd_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr_en) r_entry[w_upd_idx] <= w_wr_entry;
    r_s1_target <= w_rd_entry.target;
  end

  assign o_pred.hit    = r_s1_hit;
  assign o_pred.target = r_s1_target;

  // colliding lookup answers from the entry the update stored
  a_no_stale_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_lookup && w_wr_en && (w_upd_idx == w_lk_idx)) |=>
      ((o_pred.target == r_entry[$past(w_upd_idx)].target) &&
       (o_pred.hit == ((r_entry[$past(w_upd_idx)].tag == $past(w_lk_tag)) &&
                       r_entry[$past(w_upd_idx)].ctr[1]))));

endmodule

//--- logic/fetch_sequencer.sv
// ==============================
// fetch sequencer
// chooses each fetch address and tracks the s1/s2 request stages
// ==============================

`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_sequencer (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fetch_pkg::redirect_t  i_redirect,
  input  logic                  i_ic_ready,
  input  fetch_pkg::ic_resp_t   i_ic_resp,
  input  fetch_pkg::pred_t      i_pred,
  input  logic                  i_ibuf_ready,
  output fetch_pkg::ic_req_t    o_ic_req,
  output fetch_pkg::fetch_out_t o_fetch
);
  import fetch_pkg::*;

  typedef enum logic [2:0] {
    init,
    fetch_req,
    wait_ic_fill,
    wait_ibuf_free,
    wait_redirect
  } fetch_state_t;

  fetch_state_t r_state;
  fetch_state_t w_state_next;

  // s0
  vaddr_t r_s0_vaddr;
  vaddr_t w_s0_vaddr;
  vaddr_t w_s0_vaddr_next;
  logic   r_s0_predicted;     // held predicted target not yet accepted
  logic   w_s0_predicted;
  logic   w_s0_predicted_next;
  logic   w_req_level;
  logic   w_redirect;
  logic   w_accept;

  // s1 / s2
  logic   r_s1_valid;
  logic   r_s1_clear;
  logic   r_s1_predicted;
  vaddr_t r_s1_vaddr;
  logic   r_s2_valid;
  logic   r_s2_clear;
  logic   r_s2_predicted;
  vaddr_t r_s2_vaddr;

  logic   w_s1_pred;
  logic   w_s2_live;
  logic   w_s2_miss;
  logic   w_s2_hit;
  logic   w_ibuf_stall;
  logic   w_s2_event;

  function automatic vaddr_t next_line(input vaddr_t a);
    return (a & ~vaddr_t'(`FETCH_LINE_BYTES - 1)) + vaddr_t'(`FETCH_LINE_BYTES);
  endfunction

  assign w_redirect   = i_redirect.valid & (r_state != init);
  assign w_s1_pred    = r_s1_valid & ~r_s1_clear & i_pred.hit;
  assign w_s2_live    = r_s2_valid & ~r_s2_clear & i_ic_resp.valid;
  assign w_s2_miss    = w_s2_live & i_ic_resp.miss;
  assign w_s2_hit     = w_s2_live & ~i_ic_resp.miss;
  assign w_ibuf_stall = w_s2_hit & ~i_ibuf_ready;
  assign w_s2_event   = ~w_redirect & (w_s2_miss | w_ibuf_stall);  // kills younger lines

  // ==============================
  // s0 request
  // ==============================
  always_comb begin
    case (r_state)
      init:           w_req_level = 1'b0;
      wait_ibuf_free: w_req_level = i_ibuf_ready;
      default:        w_req_level = 1'b1;
    endcase
  end

  assign w_s0_vaddr = w_redirect ? i_redirect.vaddr :
                      w_s1_pred  ? i_pred.target    : r_s0_vaddr;
  assign w_s0_predicted = ~w_redirect & (w_s1_pred | r_s0_predicted);

  assign o_ic_req.valid = w_redirect | w_req_level;
  assign o_ic_req.vaddr = w_s0_vaddr;
  assign w_accept       = o_ic_req.valid & i_ic_ready;

  always_comb begin
    w_state_next        = r_state;
    w_s0_vaddr_next     = w_accept ? next_line(w_s0_vaddr) : w_s0_vaddr;
    w_s0_predicted_next = ~w_accept & w_s0_predicted;
    case (r_state)
      init: w_state_next = fetch_req;
      fetch_req: begin
        if (w_redirect) begin
          if (!w_accept) w_state_next = wait_redirect;
        end else if (w_s2_miss) begin
          w_state_next        = wait_ic_fill;
          w_s0_vaddr_next     = i_ic_resp.vaddr;   // refetch the missed line
          w_s0_predicted_next = r_s2_predicted;
        end else if (w_ibuf_stall) begin
          w_state_next        = wait_ibuf_free;
          w_s0_vaddr_next     = r_s2_vaddr;
          w_s0_predicted_next = r_s2_predicted;
        end
      end
      default: begin
        if (w_accept)        w_state_next = fetch_req;
        else if (w_redirect) w_state_next = wait_redirect;
      end
    endcase
  end

  // ==============================
  // stage registers
  // ==============================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state        <= init;
      r_s0_vaddr     <= vaddr_t'(`FETCH_PC_INIT);
      r_s0_predicted <= 1'b0;
      r_s1_valid     <= 1'b0;
      r_s1_clear     <= 1'b0;
      r_s1_predicted <= 1'b0;
      r_s2_valid     <= 1'b0;
      r_s2_clear     <= 1'b0;
      r_s2_predicted <= 1'b0;
    end else begin
      r_state        <= w_state_next;
      r_s0_vaddr     <= w_s0_vaddr_next;
      r_s0_predicted <= w_s0_predicted_next;
      r_s1_valid     <= w_accept;
      r_s1_clear     <= w_s2_event;
      r_s1_predicted <= w_s0_predicted;
      r_s2_valid     <= r_s1_valid;
      r_s2_clear     <= r_s1_clear | w_redirect | w_s2_event;
      r_s2_predicted <= r_s1_predicted;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= w_s0_vaddr;
    r_s2_vaddr <= r_s1_vaddr;
  end

  // wrong-path line is dropped on a redirect
  assign o_fetch.valid     = w_s2_hit & i_ibuf_ready & ~w_redirect;
  assign o_fetch.predicted = r_s2_predicted;
  assign o_fetch.vaddr     = r_s2_vaddr;

  a_fetch_in_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_fetch.valid |-> (r_state == fetch_req));

  a_no_req_in_init: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_state == init) |-> !o_ic_req.valid);

endmodule

//--- logic/redirect_target.sv
// ==============================
// redirect target
// picks the new fetch address on commit, interrupt or mispredict
// ==============================

`timescale 1ns/100ps
`include "fetch_params.svh"

module redirect_target (
  input  fetch_pkg::commit_t   i_commit,
  input  fetch_pkg::csr_info_t i_csr,
  input  fetch_pkg::int_req_t  i_int,
  input  fetch_pkg::br_upd_t   i_br_upd,
  output fetch_pkg::redirect_t o_redirect
);
  import fetch_pkg::*;

  // interrupt cause codes
  localparam logic [3:0] int_code_s_soft  = 4'd1;
  localparam logic [3:0] int_code_m_soft  = 4'd3;
  localparam logic [3:0] int_code_s_timer = 4'd5;
  localparam logic [3:0] int_code_m_timer = 4'd7;
  localparam logic [3:0] int_code_s_ext   = 4'd9;
  localparam logic [3:0] int_code_m_ext   = 4'd11;

  logic       w_commit_int;
  logic       w_commit_flush;
  logic       w_br_flush;
  logic       w_cause_ok;
  logic [3:0] w_int_code;
  vaddr_t     w_int_vaddr;
  vaddr_t     w_trap_vec;
  vaddr_t     w_flush_vaddr;

  assign w_commit_int   = i_commit.valid & (|i_int);
  assign w_commit_flush = i_commit.valid & i_commit.flush;
  assign w_br_flush     = i_br_upd.valid & i_br_upd.mispredict;

  // ==============================
  // interrupt entry
  // ==============================
  always_comb begin
    if (i_int.m_ext)        w_int_code = int_code_m_ext;
    else if (i_int.s_ext)   w_int_code = int_code_s_ext;
    else if (i_int.m_timer) w_int_code = int_code_m_timer;
    else if (i_int.s_timer) w_int_code = int_code_s_timer;
    else if (i_int.m_soft)  w_int_code = int_code_m_soft;
    else                    w_int_code = int_code_s_soft;
  end

  assign w_int_vaddr = {i_csr.mtvec[`FETCH_VADDR_W-1:1], 1'b0} +
                       {{(`FETCH_VADDR_W-6){1'b0}}, w_int_code, 2'b00};

  // ==============================
  // commit flush target
  // ==============================
  assign w_trap_vec = i_csr.medeleg[i_commit.cause[3:0]] ? i_csr.stvec : i_csr.mtvec;

  always_comb begin
    w_cause_ok = 1'b1;
    case (i_commit.cause)
      silent_flush:  w_flush_vaddr = i_commit.epc + vaddr_t'(4);  // next instruction
      another_flush: w_flush_vaddr = i_commit.epc;                // replay
      mret:          w_flush_vaddr = i_csr.mepc;
      sret:          w_flush_vaddr = i_csr.sepc;
      ecall_u, ecall_s, ecall_m, inst_acc_fault, inst_page_fault,
      inst_addr_misalign, illegal_inst: begin
        w_flush_vaddr = w_trap_vec;
      end
      default: begin
        w_flush_vaddr = '0;
        w_cause_ok    = 1'b0;
      end
    endcase
  end

  // interrupt beats flush beats mispredict
  assign o_redirect.valid = w_commit_int | w_commit_flush | w_br_flush;

  always_comb begin
    if (w_commit_int)        o_redirect.vaddr = w_int_vaddr;
    else if (w_commit_flush) o_redirect.vaddr = w_flush_vaddr;
    else                     o_redirect.vaddr = i_br_upd.target;
  end

  always_comb begin
    if (w_commit_flush && !w_commit_int) begin
      a_flush_cause: assert (w_cause_ok)
        else $error("commit flush with unsupported cause %0d", i_commit.cause);
    end
  end

endmodule

//--- logic/fetch_pkg.sv
// ==============================
// fetch frontend types
// structs and enums shared across the fetch-address path
// ==============================

`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`FETCH_VADDR_W-1:0] vaddr_t;

  // standard exception codes where one exists, so medeleg indexes directly
  typedef enum logic [4:0] {
    inst_addr_misalign = 5'd0,
    inst_acc_fault     = 5'd1,
    illegal_inst       = 5'd2,
    ecall_u            = 5'd8,
    ecall_s            = 5'd9,
    ecall_m            = 5'd11,
    inst_page_fault    = 5'd12,
    silent_flush       = 5'd16,   // non-standard, above the trap range
    another_flush      = 5'd17,
    mret               = 5'd18,
    sret               = 5'd19
  } except_t;

  typedef struct packed {
    logic    valid;
    logic    flush;
    except_t cause;
    vaddr_t  epc;
  } commit_t;

  typedef struct packed {
    vaddr_t      mtvec;
    vaddr_t      stvec;
    vaddr_t      mepc;
    vaddr_t      sepc;
    logic [15:0] medeleg;
  } csr_info_t;

  typedef struct packed {
    logic m_ext;
    logic s_ext;
    logic m_timer;
    logic s_timer;
    logic m_soft;
    logic s_soft;
  } int_req_t;

  typedef struct packed {
    logic   valid;
    logic   mispredict;
    logic   taken;
    vaddr_t pc;
    vaddr_t target;
  } br_upd_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } redirect_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  typedef struct packed {
    logic   valid;
    logic   miss;
    vaddr_t vaddr;
  } ic_resp_t;

  // s1 answer from the BTB
  typedef struct packed {
    logic   hit;
    vaddr_t target;
  } pred_t;

  // line handed to the instruction buffer
  typedef struct packed {
    logic   valid;
    logic   predicted;
    vaddr_t vaddr;
  } fetch_out_t;

endpackage

//--- logic/fetch_params.svh
// ==============================
// fetch frontend constants
// address width, line geometry, BTB depth and reset PC
// ==============================

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// virtual fetch address width (sv39)
`define FETCH_VADDR_W 39

// bytes per fetch line
`define FETCH_LINE_BYTES 16
`define FETCH_LINE_OFS_W $clog2(`FETCH_LINE_BYTES)

// direct-mapped BTB
`define FETCH_BTB_ENTRIES 16
`define FETCH_BTB_IDX_W $clog2(`FETCH_BTB_ENTRIES)

// first fetch after reset
`define FETCH_PC_INIT 'h8000_0000

`endif
